// ==== sim.f ====
hdl/mem_side_pkg.sv
hdl/flush_sequencer.sv
hdl/mem_req_queue.sv
hdl/mem_side_top.sv
sim/mem_side_assertions.sv
sim/mem_side_checker.sv
sim/tb_mem_side.sv

// ==== Makefile ====
# Verilator build and run for the memory-side testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_side
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_mem_side.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_side
   import mem_side_pkg::*;
();

   localparam int clk_period = 40;
   localparam int reset_cycles = 10;
   localparam logic [31:0] lfsr_seed = 32'h2caf_53ca;
   localparam int timeout_margin = 50;
   localparam int lg_queue_depth = lg_req_tags + 1;
   localparam int max_steps = 40;

   // drive bit order fl_i fl_d c_i c_d c_l2 push gnt rsp rnd
   typedef struct packed
   {
      logic [8:0]   drive;
      logic [7:0]   active;
      logic [7:0]   idle;
      logic [159:0] name;
   } step_t;

   step_t steps [max_steps];
   int num_steps;
   int cycle_count;
   int cycle_limit;
   logic [31:0] lfsr;
   logic [159:0] cur_name;
   int error_count;

   logic clk;
   logic reset;
   logic flush_req_l1i;
   logic flush_req_l1d;
   logic l1i_flush_complete;
   logic l1d_flush_complete;
   logic l2_flush_complete;
   logic in_flush_mode;
   logic flush_l2;
   logic req_valid;
   mem_req_t req;
   logic queue_full;
   logic mem_req_valid;
   mem_req_t mem_req;
   logic mem_req_gnt;
   logic mem_rsp_valid;
   logic [lg_queue_depth:0] inflight;

   mem_side_top #(.lg_queue_depth(lg_queue_depth)) i_mem_side_top (.*);

   mem_side_checker #(.lg_queue_depth(lg_queue_depth)) i_mem_side_checker
   (
      .test_name (cur_name),
      .*
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [127:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[126:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic add_step(input logic [8:0] drive, input int active, input int idle,
                           input logic [159:0] name);
      steps[num_steps] = '{drive, active[7:0], idle[7:0], name};
      num_steps++;
   endtask

   task automatic drive_cycle(input step_t s, input logic on);
      logic [8:0] d;
      logic [127:0] v;
      d = on ? s.drive : 9'b0;
      if (d[0])
      begin
         take_bits(3, v);
         d[3:1] = d[3:1] & v[2:0];
      end
      flush_req_l1i = d[8];
      flush_req_l1d = d[7];
      l1i_flush_complete = d[6];
      l1d_flush_complete = d[5];
      l2_flush_complete = d[4];
      req_valid = d[3] && !queue_full;
      mem_req_gnt = d[2] && mem_req_valid;
      mem_rsp_valid = d[1] && (inflight != '0);
      if (req_valid)
      begin
         take_bits(32, v);
         req.addr = v[31:0];
         take_bits(lg_req_tags, v);
         req.tag = v[lg_req_tags-1:0];
         take_bits(line_bits, v);
         req.data = v;
         take_bits(2, v);
         req.opcode = mem_opcode_t'({3'b000, v[1:0]});
      end
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Finished with errors");
         $finish;
      end
   end

   initial
   begin
      lfsr = lfsr_seed;
      cycle_count = 0;
      num_steps = 0;
      cur_name = "reset";
      reset = 1'b1;
      req = '0;
      drive_cycle('0, 1'b0);

      add_step(9'b110_00_000_0, 1, 2, "both d then i");
      add_step(9'b000_10_000_0, 1, 2, "both d then i");
      add_step(9'b001_00_000_0, 1, 2, "both d then i");
      add_step(9'b000_01_000_0, 1, 3, "both d then i");
      add_step(9'b110_00_000_0, 1, 2, "both i then d");
      add_step(9'b001_00_000_0, 1, 2, "both i then d");
      add_step(9'b000_10_000_0, 1, 2, "both i then d");
      add_step(9'b000_01_000_0, 1, 3, "both i then d");
      add_step(9'b110_00_000_0, 1, 2, "both together");
      add_step(9'b001_10_000_0, 1, 2, "both together");
      add_step(9'b000_01_000_0, 1, 3, "both together");
      add_step(9'b100_00_000_0, 1, 2, "only l1i");
      add_step(9'b000_10_000_0, 1, 2, "only l1i");
      add_step(9'b001_00_000_0, 1, 2, "only l1i");
      add_step(9'b000_01_000_0, 1, 3, "only l1i");
      add_step(9'b010_00_000_0, 1, 2, "only l1d");
      add_step(9'b001_00_000_0, 1, 2, "only l1d");
      add_step(9'b000_10_000_0, 1, 2, "only l1d");
      add_step(9'b000_01_000_0, 1, 3, "only l1d");
      add_step(9'b000_00_111_1, 80, 2, "request order");
      add_step(9'b000_00_011_0, 40, 2, "drain");
      add_step(9'b000_00_100_0, 24, 3, "back pressure");
      add_step(9'b000_00_111_0, 12, 1, "inflight push rsp");
      add_step(9'b000_00_011_0, 40, 3, "final drain");

      cycle_limit = reset_cycles + timeout_margin;
      for (int i = 0; i < num_steps; i++)
      begin
         cycle_limit += int'(steps[i].active) + int'(steps[i].idle);
      end

      repeat (reset_cycles) @(posedge clk);
      #2 reset = 1'b0;

      for (int i = 0; i < num_steps; i++)
      begin
         for (int k = 0; k < int'(steps[i].active); k++)
         begin
            @(posedge clk);
            #2;
            cur_name = steps[i].name;
            drive_cycle(steps[i], 1'b1);
         end
         for (int k = 0; k < int'(steps[i].idle); k++)
         begin
            @(posedge clk);
            #2 drive_cycle(steps[i], 1'b0);
         end
         // a flush ends when flush mode drops
         if (steps[i].drive[4])
         begin
            while (in_flush_mode)
            begin
               @(posedge clk);
               #2;
            end
         end
      end

      repeat (3) @(posedge clk);
      $display("%0d errors in %0d cycles", error_count, cycle_count);
      if (error_count == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/mem_side_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_side_checker
   import mem_side_pkg::*;
#(
   parameter int lg_queue_depth = 4
)
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [159:0]            test_name,
   input  logic                    flush_req_l1i,
   input  logic                    flush_req_l1d,
   input  logic                    l1i_flush_complete,
   input  logic                    l1d_flush_complete,
   input  logic                    l2_flush_complete,
   input  logic                    in_flush_mode,
   input  logic                    flush_l2,
   input  logic                    req_valid,
   input  mem_req_t                req,
   input  logic                    queue_full,
   input  logic                    mem_req_valid,
   input  mem_req_t                mem_req,
   input  logic                    mem_req_gnt,
   input  logic                    mem_rsp_valid,
   input  logic [lg_queue_depth:0] inflight,
   output int                      error_count
);

   mem_req_t model_q[$];
   int model_inflight;

   // flush model
   logic exp_mode;
   logic exp_l2;
   logic need_i;
   logic need_d;
   logic wait_l2;

   initial error_count = 0;

   task automatic compare(input string what, input logic [255:0] exp, input logic [255:0] act);
      if (exp !== act)
      begin
         $display("FAILED %0s: %0s expected %0h actual %0h", test_name, what, exp, act);
         error_count++;
      end
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         model_q.delete();
         model_inflight = 0;
         exp_mode <= 1'b0;
         exp_l2 <= 1'b0;
         need_i <= 1'b0;
         need_d <= 1'b0;
         wait_l2 <= 1'b0;
      end
      else
      begin
         compare("in_flush_mode", 256'(exp_mode), 256'(in_flush_mode));
         compare("flush_l2", 256'(exp_l2), 256'(flush_l2));
         compare("mem_req_valid", 256'(model_q.size() != 0), 256'(mem_req_valid));
         compare("queue_full", 256'(model_q.size() == (1 << lg_queue_depth)), 256'(queue_full));
         compare("inflight", 256'(model_inflight), 256'(inflight));
         if (model_q.size() != 0)
         begin
            compare("mem_req", 256'(model_q[0]), 256'(mem_req));
         end

         if (mem_req_gnt && model_q.size() != 0)
         begin
            void'(model_q.pop_front());
         end
         if (req_valid)
         begin
            model_q.push_back(req);
         end
         if (req_valid && !mem_rsp_valid)
         begin
            model_inflight++;
         end
         else if (!req_valid && mem_rsp_valid)
         begin
            model_inflight--;
         end

         exp_l2 <= 1'b0;
         if (!exp_mode)
         begin
            if (flush_req_l1i || flush_req_l1d)
            begin
               exp_mode <= 1'b1;
               need_i <= flush_req_l1i;
               need_d <= flush_req_l1d;
            end
         end
         else if (wait_l2)
         begin
            if (l2_flush_complete)
            begin
               exp_mode <= 1'b0;
               wait_l2 <= 1'b0;
            end
         end
         else if ((!need_i || l1i_flush_complete) && (!need_d || l1d_flush_complete))
         begin
            exp_l2 <= 1'b1;
            wait_l2 <= 1'b1;
         end
         else
         begin
            need_i <= need_i && !l1i_flush_complete;
            need_d <= need_d && !l1d_flush_complete;
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/mem_side_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_side_assertions
   import mem_side_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input logic     req_valid,
   input logic     queue_full,
   input logic     mem_req_valid,
   input mem_req_t mem_req,
   input logic     mem_req_gnt
);

   // source owns back-pressure
   no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      req_valid |-> !queue_full)
      else $error("push while queue full");

   head_stable: assert property (@(posedge clk) disable iff (reset)
      (mem_req_valid && !mem_req_gnt) |=> (mem_req_valid && $stable(mem_req)))
      else $error("head entry changed before grant");

   no_grant_when_empty: assert property (@(posedge clk) disable iff (reset)
      mem_req_gnt |-> mem_req_valid)
      else $error("grant while queue empty");

endmodule

bind mem_req_queue mem_side_assertions i_mem_side_assertions
(
   .clk           (clk),
   .reset         (reset),
   .req_valid     (req_valid),
   .queue_full    (queue_full),
   .mem_req_valid (mem_req_valid),
   .mem_req       (mem_req),
   .mem_req_gnt   (mem_req_gnt)
);

`default_nettype wire

// ==== hdl/mem_side_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_side_top
   import mem_side_pkg::*;
#(
   // one extra bit over the tag space
   parameter int lg_queue_depth = lg_req_tags + 1
)
(
   input  logic                    clk,
   input  logic                    reset,

   // flush control
   input  logic                    flush_req_l1i,
   input  logic                    flush_req_l1d,
   input  logic                    l1i_flush_complete,
   input  logic                    l1d_flush_complete,
   input  logic                    l2_flush_complete,
   output logic                    in_flush_mode,
   output logic                    flush_l2,

   // request source
   input  logic                    req_valid,
   input  mem_req_t                req,
   output logic                    queue_full,

   // memory port
   output logic                    mem_req_valid,
   output mem_req_t                mem_req,
   input  logic                    mem_req_gnt,
   input  logic                    mem_rsp_valid,
   output logic [lg_queue_depth:0] inflight
);

   flush_sequencer i_flush_sequencer
   (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1i      (flush_req_l1i),
      .flush_req_l1d      (flush_req_l1d),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .in_flush_mode      (in_flush_mode),
      .flush_l2           (flush_l2)
   );

   // outbound queue toward memory
   mem_req_queue
   #(
      .lg_queue_depth (lg_queue_depth)
   )
   i_mem_req_queue
   (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req           (req),
      .mem_req_gnt   (mem_req_gnt),
      .mem_rsp_valid (mem_rsp_valid),
      .queue_full    (queue_full),
      .mem_req_valid (mem_req_valid),
      .mem_req       (mem_req),
      .inflight      (inflight)
   );

endmodule

`default_nettype wire

// ==== hdl/mem_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_req_queue
   import mem_side_pkg::*;
#(
   parameter int lg_queue_depth = 4
)
(
   input  logic                    clk,
   input  logic                    reset,

   // request source pushes on every valid cycle
   input  logic                    req_valid,
   input  mem_req_t                req,

   // memory side
   input  logic                    mem_req_gnt,
   input  logic                    mem_rsp_valid,

   output logic                    queue_full,
   output logic                    mem_req_valid,
   output mem_req_t                mem_req,
   output logic [lg_queue_depth:0] inflight
);

   localparam int queue_depth = 1 << lg_queue_depth;

   // request storage
   mem_req_t q_mem [queue_depth];

   // pointers carry one extra wrap bit
   logic [lg_queue_depth:0] r_head_ptr;
   logic [lg_queue_depth:0] n_head_ptr;
   logic [lg_queue_depth:0] r_tail_ptr;
   logic [lg_queue_depth:0] n_tail_ptr;

   logic [lg_queue_depth-1:0] head_idx;
   logic [lg_queue_depth-1:0] tail_idx;

   logic [lg_queue_depth:0] r_inflight;
   logic [lg_queue_depth:0] n_inflight;

   logic q_empty;
   logic q_full;
   logic push;
   logic pop;

   assign head_idx = r_head_ptr[lg_queue_depth-1:0];
   assign tail_idx = r_tail_ptr[lg_queue_depth-1:0];

   assign q_empty = (r_head_ptr == r_tail_ptr);
   // same slot on a different lap
   assign q_full = (r_head_ptr[lg_queue_depth] != r_tail_ptr[lg_queue_depth]) &&
                   (head_idx == tail_idx);

   assign push = req_valid;
   assign pop = mem_req_gnt && !q_empty;

   always_comb
   begin
      n_head_ptr = r_head_ptr;
      n_tail_ptr = r_tail_ptr;

      if (push)
      begin
         n_tail_ptr = r_tail_ptr + 1'b1;
      end
      if (pop)
      begin
         n_head_ptr = r_head_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         r_head_ptr <= n_head_ptr;
         r_tail_ptr <= n_tail_ptr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         q_mem[tail_idx] <= req;
      end
   end

   // outstanding transactions
   always_comb
   begin
      n_inflight = r_inflight;

      if (push && !mem_rsp_valid)
      begin
         n_inflight = r_inflight + 1'b1;
      end
      else if (!push && mem_rsp_valid)
      begin
         n_inflight = r_inflight - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_inflight <= '0;
      end
      else
      begin
         r_inflight <= n_inflight;
      end
   end

   // head entry held until granted
   assign mem_req_valid = !q_empty;
   assign mem_req = q_mem[head_idx];

   assign queue_full = q_full;
   assign inflight = r_inflight;

endmodule

`default_nettype wire

// ==== hdl/flush_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module flush_sequencer
   import mem_side_pkg::*;
(
   input  logic clk,
   input  logic reset,

   // single-cycle flush request pulses
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,

   // completion pulses from the caches
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_complete,

   output logic in_flush_mode,
   output logic flush_l2
);

   flush_state_t r_flush_state;
   flush_state_t n_flush_state;

   logic r_flush;
   logic n_flush;
   logic r_flush_l2;
   logic n_flush_l2;

   assign in_flush_mode = r_flush;
   assign flush_l2 = r_flush_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_flush_state <= flush_idle;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_flush_state <= n_flush_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   always_comb
   begin
      n_flush_state = r_flush_state;
      n_flush = r_flush;
      // l2 command is a single pulse
      n_flush_l2 = 1'b0;

      case (r_flush_state)
         flush_idle:
         begin
            if (flush_req_l1i && flush_req_l1d)
            begin
               n_flush_state = wait_for_l1d_l1i;
               n_flush = 1'b1;
            end
            else if (flush_req_l1i)
            begin
               // no l1d flush asked so it counts as done
               n_flush_state = got_l1d;
               n_flush = 1'b1;
            end
            else if (flush_req_l1d)
            begin
               n_flush_state = got_l1i;
               n_flush = 1'b1;
            end
         end

         wait_for_l1d_l1i:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_flush_state = mem_side_pkg::flush_l2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
            begin
               n_flush_state = got_l1d;
            end
            else if (l1i_flush_complete)
            begin
               n_flush_state = got_l1i;
            end
         end

         got_l1d:
         begin
            // only the icache is still pending
            if (l1i_flush_complete)
            begin
               n_flush_state = mem_side_pkg::flush_l2;
               n_flush_l2 = 1'b1;
            end
         end

         got_l1i:
         begin
            if (l1d_flush_complete)
            begin
               n_flush_state = mem_side_pkg::flush_l2;
               n_flush_l2 = 1'b1;
            end
         end

         mem_side_pkg::flush_l2:
         begin
            // flush mode ends with the l2
            if (l2_flush_complete)
            begin
               n_flush_state = flush_idle;
               n_flush = 1'b0;
            end
         end

         default:
         begin
            n_flush_state = flush_idle;
            n_flush = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/mem_side_pkg.sv ====
`default_nettype none

package mem_side_pkg;

   // physical address width
   localparam int pa_width = 32;

   // log2 of the number of memory request tags
   localparam int lg_req_tags = 3;

   // one cache line of load or store data
   localparam int line_bits = 128;

   // memory port operations
   typedef enum logic [4:0]
   {
      mem_load_line  = 5'd0,
      mem_store_line = 5'd1,
      mem_load_word  = 5'd2,
      mem_store_word = 5'd3
   } mem_opcode_t;

   // flush sequencing
   typedef enum logic [2:0]
   {
      flush_idle       = 3'd0,
      wait_for_l1d_l1i = 3'd1,
      got_l1d          = 3'd2,
      got_l1i          = 3'd3,
      flush_l2         = 3'd4
   } flush_state_t;

   // one outbound request toward memory
   typedef struct packed
   {
      logic [pa_width-1:0]    addr;
      logic [lg_req_tags-1:0] tag;
      logic [line_bits-1:0]   data;
      mem_opcode_t            opcode;
   } mem_req_t;

endpackage

`default_nettype wire
